// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = schmidl_cox_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/axis_if.sv
`timescale 1ns/100ps

interface axis_if #(
   parameter type T = logic [31:0]
);

   T     tdata;
   logic tlast;
   logic tvalid;
   logic tready;

   // source side
   modport mst (
      output tdata,
      output tlast,
      output tvalid,
      input  tready
   );

   // sink side
   modport slv (
      input  tdata,
      input  tlast,
      input  tvalid,
      output tready
   );

endinterface

// File: hw/complex_to_magsq.sv
`timescale 1ns/100ps

module complex_to_magsq
   import sc_sample_pkg::*;
(
   input logic clk,
   input logic i_reset,
   axis_if.slv s,
   axis_if.mst m
);

   iq_t                   in_d;
   logic [2*SAMPLE_W-1:0] sq_i, sq_q;
   logic [POW_W-1:0]      mag;
   logic                  v1, l1, v2, l2;
   logic                  en1, en2;

   assign in_d     = s.tdata;
   assign en2      = !v2 || m.tready;
   assign en1      = !v1 || en2;
   assign s.tready = en1;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         v1 <= 1'b0;
         v2 <= 1'b0;
      end else begin
         if (en1)
            v1 <= s.tvalid;
         if (en2)
            v2 <= v1;
      end
   end

   always_ff @(posedge clk) begin
      if (en1 && s.tvalid) begin
         sq_i <= in_d.i * in_d.i;            // squares are never negative
         sq_q <= in_d.q * in_d.q;
         l1   <= s.tlast;
      end
      if (en2 && v1) begin
         mag <= sq_i + sq_q;
         l2  <= l1;
      end
   end

   assign m.tdata  = mag;
   assign m.tlast  = l2;
   assign m.tvalid = v2;

endmodule

// File: hw/conj_mult.sv
`timescale 1ns/100ps

module conj_mult
   import sc_sample_pkg::*;
(
   input logic clk,
   input logic i_reset,
   axis_if.slv a,
   axis_if.slv b,
   axis_if.mst m
);

   iq_t                          a_d;
   iq_t                          b_d;
   logic                         a_l, a_v;
   logic signed [2*SAMPLE_W-1:0] p_ii, p_qq, p_qi, p_iq;
   logic signed [2*SAMPLE_W:0]   s_re, s_im;
   logic                         l1, v1;
   iq_t                          p_d;
   logic                         l2, v2;
   logic                         adv1, adv2, join_fire;

   function automatic logic signed [SAMPLE_W-1:0] sat_q15(input logic signed [2*SAMPLE_W:0] x);
      logic signed [2*SAMPLE_W:0] sh;
      sh = x >>> (SAMPLE_W - 1);
      if (sh > (2**(SAMPLE_W-1) - 1))
         return {1'b0, {(SAMPLE_W-1){1'b1}}};
      else if (sh < -(2**(SAMPLE_W-1)))
         return {1'b1, {(SAMPLE_W-1){1'b0}}};
      else
         return sh[SAMPLE_W-1:0];
   endfunction

   assign b_d       = b.tdata;
   assign adv2      = !v2 || m.tready;
   assign adv1      = !v1 || adv2;
   assign join_fire = a_v && b.tvalid && adv1;   // live copy waits here for b

   assign a.tready  = !a_v || join_fire;
   assign b.tready  = a_v && adv1;

   assign s_re = p_ii + p_qq;
   assign s_im = p_qi - p_iq;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         a_v <= 1'b0;
         v1  <= 1'b0;
         v2  <= 1'b0;
      end else begin
         if (a.tvalid && a.tready)
            a_v <= 1'b1;
         else if (join_fire)
            a_v <= 1'b0;
         if (adv1)
            v1 <= join_fire;
         if (adv2)
            v2 <= v1;
      end
   end

   always_ff @(posedge clk) begin
      if (a.tvalid && a.tready) begin
         a_d <= a.tdata;
         a_l <= a.tlast;
      end
      if (join_fire) begin
         p_ii <= a_d.i * b_d.i;
         p_qq <= a_d.q * b_d.q;
         p_qi <= a_d.q * b_d.i;
         p_iq <= a_d.i * b_d.q;
         l1   <= a_l;
      end
      if (adv2 && v1) begin
         p_d.i <= sat_q15(s_re);
         p_d.q <= sat_q15(s_im);
         l2    <= l1;
      end
   end

   assign m.tdata  = p_d;
   assign m.tlast  = l2;
   assign m.tvalid = v2;

   // live and delayed copies come from the same fork transfer
   a_last_match: assert property (@(posedge clk) disable iff (i_reset)
      join_fire |-> (a_l == b.tlast));

endmodule

// File: hw/metric_divide.sv
`timescale 1ns/100ps

module metric_divide
   import sc_sample_pkg::*;
   import sc_detect_pkg::*;
(
   input logic clk,
   input logic i_reset,
   input logic i_clear,
   axis_if.slv dividend,
   axis_if.slv divisor,
   axis_if.mst m
);

   logic                                   busy;
   logic [$clog2(POW_W+METRIC_FRAC+1)-1:0] step;
   logic [POW_W-1:0]                       rem, div_r;
   logic [POW_W+METRIC_FRAC-1:0]           quo;
   logic [POW_W:0]                         trial;
   logic [POW_W-1:0]                       res;
   logic                                   last_r;
   logic                                   out_v;
   logic                                   idle, pair, finish;

   assign idle  = !busy && !out_v;           // one item at a time
   assign pair  = dividend.tvalid && divisor.tvalid && idle;
   assign finish = busy && (step == (POW_W + METRIC_FRAC - 1));   // last step
   assign trial = {rem, quo[POW_W+METRIC_FRAC-1]};

   assign dividend.tready = idle && divisor.tvalid;
   assign divisor.tready  = idle && dividend.tvalid;

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         busy  <= 1'b0;
         step  <= '0;
         out_v <= 1'b0;
      end else begin
         if (out_v && m.tready)
            out_v <= 1'b0;
         if (pair) begin
            busy <= 1'b1;
            step <= '0;
         end else if (finish) begin
            busy  <= 1'b0;
            out_v <= 1'b1;
         end else if (busy) begin
            step <= step + 1'b1;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // restoring division, one bit per clock
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (pair) begin
         rem    <= '0;
         quo    <= {dividend.tdata, {METRIC_FRAC{1'b0}}};
         div_r  <= divisor.tdata;
         last_r <= dividend.tlast;
      end else if (busy) begin
         if (trial >= {1'b0, div_r}) begin
            rem <= POW_W'(trial - {1'b0, div_r});
            quo <= {quo[POW_W+METRIC_FRAC-2:0], 1'b1};
         end else begin
            rem <= trial[POW_W-1:0];
            quo <= {quo[POW_W+METRIC_FRAC-2:0], 1'b0};
         end
      end
   end

   assign res = (div_r == '0 || |quo[POW_W+METRIC_FRAC-1:POW_W]) ?
                '1 : quo[POW_W-1:0];         // saturate, also for zero power

   assign m.tdata  = res;
   assign m.tlast  = last_r;
   assign m.tvalid = out_v;

   // fixed latency from pair to result
   a_div_latency: assert property (@(posedge clk) disable iff (i_reset || i_clear)
      pair |-> ##(POW_W + METRIC_FRAC + 1) m.tvalid);

endmodule

// File: hw/moving_sum.sv
`timescale 1ns/100ps

module moving_sum
   import sc_sample_pkg::*;
   import sc_detect_pkg::*;
#(
   parameter int WIDTH     = 16,
   parameter bit SIGNED_IN = 1'b1
) (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_clear,
   input  logic [WIDTH-1:0]            i_tdata,
   input  logic                        i_tlast,
   input  logic                        i_tvalid,
   output logic                        o_tready,
   output logic [WIDTH+SUM_GROWTH-1:0] o_tdata,
   output logic                        o_tlast,
   output logic                        o_tvalid,
   input  logic                        i_tready
);

   logic [WIDTH-1:0]            hist [WINDOW_LEN];
   logic [WINDOW_LOG2-1:0]      wr_ptr;
   logic [WINDOW_LOG2-1:0]      clr_ptr;
   logic                        clr_busy;
   logic [WIDTH-1:0]            old_d;
   logic [WIDTH+SUM_GROWTH-1:0] in_ext, old_ext;
   logic [WIDTH+SUM_GROWTH-1:0] acc;
   logic                        out_v;
   logic                        in_fire;

   assign o_tready = !clr_busy && (!out_v || i_tready);
   assign in_fire  = i_tvalid && o_tready;

   assign old_d   = hist[wr_ptr];            // sample leaving the window
   assign in_ext  = {{SUM_GROWTH{SIGNED_IN && i_tdata[WIDTH-1]}}, i_tdata};
   assign old_ext = {{SUM_GROWTH{SIGNED_IN && old_d[WIDTH-1]}}, old_d};

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         clr_busy <= 1'b1;
         clr_ptr  <= '0;
         wr_ptr   <= '0;
         acc      <= '0;
         out_v    <= 1'b0;
      end else begin
         if (clr_busy) begin
            clr_ptr <= clr_ptr + 1'b1;
            if (clr_ptr == WINDOW_LOG2'(WINDOW_LEN - 1))
               clr_busy <= 1'b0;
         end
         if (in_fire) begin
            acc   <= acc + in_ext - old_ext; // add new, drop oldest
            out_v <= 1'b1;
            if (wr_ptr == WINDOW_LOG2'(WINDOW_LEN - 1))
               wr_ptr <= '0;
            else
               wr_ptr <= wr_ptr + 1'b1;
         end else if (i_tready) begin
            out_v <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clr_busy) begin
         hist[clr_ptr] <= '0;
      end else if (in_fire) begin
         hist[wr_ptr]  <= i_tdata;
         o_tlast       <= i_tlast;
      end
   end

   assign o_tdata  = acc;
   assign o_tvalid = out_v;

endmodule

// File: hw/sample_delay.sv
`timescale 1ns/100ps

module sample_delay
   import sc_sample_pkg::*;
   import sc_detect_pkg::*;
(
   input logic clk,
   input logic i_reset,
   input logic i_clear,
   axis_if.slv s,
   axis_if.mst m
);

   iq_t                   mem [DELAY_LEN];
   logic [DELAY_LOG2-1:0] wr_ptr;
   logic [DELAY_LOG2-1:0] clr_ptr;
   logic                  clr_busy;
   iq_t                   out_d;
   logic                  out_l;
   logic                  out_v;
   logic                  in_fire;

   assign s.tready = !clr_busy && (!out_v || m.tready);
   assign in_fire  = s.tvalid && s.tready;

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         clr_busy <= 1'b1;                   // zero the history first
         clr_ptr  <= '0;
         wr_ptr   <= '0;
         out_v    <= 1'b0;
      end else begin
         if (clr_busy) begin
            clr_ptr <= clr_ptr + 1'b1;
            if (clr_ptr == DELAY_LOG2'(DELAY_LEN - 1))
               clr_busy <= 1'b0;
         end
         if (in_fire) begin
            wr_ptr <= wr_ptr + 1'b1;         // 16 deep, wraps naturally
            out_v  <= 1'b1;
         end else if (m.tready) begin
            out_v  <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clr_busy) begin
         mem[clr_ptr] <= '0;
      end else if (in_fire) begin
         out_d        <= mem[wr_ptr];        // oldest entry leaves
         out_l        <= s.tlast;            // tlast of the new sample
         mem[wr_ptr]  <= s.tdata;
      end
   end

   assign m.tdata  = out_d;
   assign m.tlast  = out_l;
   assign m.tvalid = out_v;

endmodule

// File: hw/sc_detect_pkg.sv
package sc_detect_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // preamble geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int DELAY_LEN   = 16;          // half symbol
   localparam int DELAY_LOG2  = 4;
   localparam int WINDOW_LEN  = 144;         // averaging window
   localparam int WINDOW_LOG2 = 8;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // metric scaling
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int METRIC_FRAC = 16;          // fraction bits of the ratio

endpackage

// File: hw/sc_sample_pkg.sv
package sc_sample_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sample and word widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int SAMPLE_W   = 16;           // one I or Q component
   localparam int POW_W      = 32;           // magnitude and power words
   localparam int SUM_GROWTH = 8;            // headroom for a 144 window

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // complex formats
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // The same packing is used for raw samples, for the conjugate products
   // and for the scaled correlation, so one type serves all three.
   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i;         // upper half
      logic signed [SAMPLE_W-1:0] q;         // lower half
   } iq_t;

endpackage

// File: hw/schmidl_cox.sv
`timescale 1ns/100ps

module schmidl_cox
   import sc_sample_pkg::*;
(
   input  logic             clk,
   input  logic             i_reset,
   input  logic             i_clear,
   input  iq_t              i_tdata,
   input  logic             i_tlast,
   input  logic             i_tvalid,
   output logic             i_tready,
   output logic [POW_W-1:0] o_tdata,
   output logic             o_tlast,
   output logic             o_tvalid,
   input  logic             o_tready
);

   axis_if #(.T(iq_t))              in_s ();
   axis_if #(.T(iq_t))              br_delay ();
   axis_if #(.T(iq_t))              br_live ();
   axis_if #(.T(iq_t))              br_pow ();
   axis_if #(.T(iq_t))              dly ();
   axis_if #(.T(iq_t))              prod ();
   axis_if #(.T(iq_t))              corr ();
   axis_if #(.T(logic [POW_W-1:0])) corr_pow ();
   axis_if #(.T(logic [POW_W-1:0])) pwr ();
   axis_if #(.T(logic [POW_W-1:0])) pow_div ();
   axis_if #(.T(logic [POW_W-1:0])) out_s ();

   iq_t                          prod_d;
   logic [SAMPLE_W+SUM_GROWTH-1:0] sum_i, sum_q;
   logic [POW_W+SUM_GROWTH-1:0]    sum_pow;

   assign in_s.tdata  = i_tdata;
   assign in_s.tlast  = i_tlast;
   assign in_s.tvalid = i_tvalid;
   assign i_tready    = in_s.tready;

   stream_fork split_head (.clk, .i_reset, .s(in_s), .m0(br_delay), .m1(br_live), .m2(br_pow));

   sample_delay delay_input (.clk, .i_reset, .i_clear, .s(br_delay), .m(dly));

   conj_mult cmult (.clk, .i_reset, .a(br_live), .b(dly), .m(prod));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // correlation, I and Q in lockstep
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign prod_d = prod.tdata;

   moving_sum #(.WIDTH(SAMPLE_W), .SIGNED_IN(1'b1)) corr_i (
      .clk, .i_reset, .i_clear,
      .i_tdata(prod_d.i), .i_tlast(prod.tlast), .i_tvalid(prod.tvalid), .o_tready(prod.tready),
      .o_tdata(sum_i), .o_tlast(corr.tlast), .o_tvalid(corr.tvalid), .i_tready(corr.tready));

   moving_sum #(.WIDTH(SAMPLE_W), .SIGNED_IN(1'b1)) corr_q (
      .clk, .i_reset, .i_clear,
      .i_tdata(prod_d.q), .i_tlast(prod.tlast), .i_tvalid(prod.tvalid), .o_tready(),
      .o_tdata(sum_q), .o_tlast(), .o_tvalid(), .i_tready(corr.tready));

   assign corr.tdata = {sum_i[SAMPLE_W+SUM_GROWTH-1:SUM_GROWTH],
                        sum_q[SAMPLE_W+SUM_GROWTH-1:SUM_GROWTH]};

   complex_to_magsq corr_mag (.clk, .i_reset, .s(corr), .m(corr_pow));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // input power over the window
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   complex_to_magsq pow_mag (.clk, .i_reset, .s(br_pow), .m(pwr));

   moving_sum #(.WIDTH(POW_W), .SIGNED_IN(1'b0)) pow_sum (
      .clk, .i_reset, .i_clear,
      .i_tdata(pwr.tdata), .i_tlast(pwr.tlast), .i_tvalid(pwr.tvalid), .o_tready(pwr.tready),
      .o_tdata(sum_pow), .o_tlast(pow_div.tlast), .o_tvalid(pow_div.tvalid),
      .i_tready(pow_div.tready));

   assign pow_div.tdata = sum_pow[POW_W+SUM_GROWTH-1:SUM_GROWTH];

   metric_divide div_metric (
      .clk, .i_reset, .i_clear, .dividend(corr_pow), .divisor(pow_div), .m(out_s));

   assign o_tdata      = out_s.tdata;
   assign o_tlast      = out_s.tlast;
   assign o_tvalid     = out_s.tvalid;
   assign out_s.tready = o_tready;

endmodule

// File: hw/stream_fork.sv
`timescale 1ns/100ps

module stream_fork
   import sc_sample_pkg::*;
(
   input logic clk,
   input logic i_reset,
   axis_if.slv s,
   axis_if.mst m0,
   axis_if.mst m1,
   axis_if.mst m2
);

   iq_t  fork_data;
   logic all_ready;

   assign fork_data = s.tdata;
   assign all_ready = m0.tready & m1.tready & m2.tready;   // joint ready

   assign s.tready  = all_ready;

   assign m0.tdata  = fork_data;
   assign m0.tlast  = s.tlast;
   assign m0.tvalid = s.tvalid & all_ready;

   assign m1.tdata  = fork_data;
   assign m1.tlast  = s.tlast;
   assign m1.tvalid = s.tvalid & all_ready;

   assign m2.tdata  = fork_data;
   assign m2.tlast  = s.tlast;
   assign m2.tvalid = s.tvalid & all_ready;

endmodule

// File: verif/schmidl_cox_tb.sv
`timescale 1ns/100ps

module schmidl_cox_tb
   import sc_sample_pkg::*;
   import sc_detect_pkg::*;
();

   localparam int          SEND_TIMEOUT  = 2000;    // cycles for one input transfer
   localparam int          DRAIN_TIMEOUT = 20000;
   localparam logic [31:0] SEED          = 32'hac60;

   logic             clk;
   logic             i_reset;
   logic             i_clear;
   iq_t              i_tdata;
   logic             i_tlast;
   logic             i_tvalid;
   logic             i_tready;
   logic [POW_W-1:0] o_tdata;
   logic             o_tlast;
   logic             o_tvalid;
   logic             o_tready;

   iq_t              hist [$];                  // samples since the last clear
   iq_t              pkt [$];
   iq_t              replay_d [$];
   logic             replay_l [$];
   logic [POW_W-1:0] exp_metric [$];
   logic             exp_last [$];
   logic [POW_W-1:0] first_run [$];
   logic [POW_W-1:0] second_run [$];
   logic [31:0]      rng_data = SEED;
   logic [31:0]      rng_ready;
   bit               stall_en = 1'b0;
   bit               record = 1'b0;
   bit               abort = 1'b0;
   int               capture_sel = 0;
   int               n_sent = 0;
   int               n_recv = 0;
   int               value_errs = 0;
   int               count_errs = 0;
   int               timeouts = 0;

   schmidl_cox schmidl_cox_i (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_clear  (i_clear),
      .i_tdata  (i_tdata),
      .i_tlast  (i_tlast),
      .i_tvalid (i_tvalid),
      .i_tready (i_tready),
      .o_tdata  (o_tdata),
      .o_tlast  (o_tlast),
      .o_tvalid (o_tvalid),
      .o_tready (o_tready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // random numbers and reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic iq_t random_sample(input int shift);
      iq_t s;
      rng_data = xorshift32(rng_data);
      s.i = $signed(rng_data[31:16]) >>> shift;
      s.q = $signed(rng_data[15:0]) >>> shift;
      return s;
   endfunction

   function automatic longint saturate16(input longint v);
      if (v > 32767)
         return 32767;
      if (v < -32768)
         return -32768;
      return v;
   endfunction

   // expected metric of sample n over the history since the last clear
   function automatic logic [POW_W-1:0] sc_metric(input int n);
      longint re_sum, im_sum, pow_sum;
      longint xi, xq, di, dq;
      longint ci, cq, num, den, quo;
      int     m;
      re_sum  = 0;
      im_sum  = 0;
      pow_sum = 0;
      for (m = n - WINDOW_LEN + 1; m <= n; m++) begin
         if (m >= 0) begin
            xi = hist[m].i;
            xq = hist[m].q;
            di = 0;                             // zero before the first half symbol
            dq = 0;
            if (m >= DELAY_LEN) begin
               di = hist[m - DELAY_LEN].i;
               dq = hist[m - DELAY_LEN].q;
            end
            re_sum  += saturate16((xi * di + xq * dq) >>> 15);
            im_sum  += saturate16((xq * di - xi * dq) >>> 15);
            pow_sum += xi * xi + xq * xq;
         end
      end
      ci  = re_sum >>> SUM_GROWTH;
      cq  = im_sum >>> SUM_GROWTH;
      num = (ci * ci + cq * cq) << METRIC_FRAC;
      den = pow_sum >>> SUM_GROWTH;
      if (den == 0)
         return '1;
      quo = num / den;
      if (quo > 64'd4294967295)
         return '1;
      return POW_W'(quo);
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_metric(input string name, input logic [POW_W-1:0] expv,
                               input logic [POW_W-1:0] actv);
      if (actv !== expv) begin
         $display("FAILED t=%0t %s expected %h actual %h", $time, name, expv, actv);
         value_errs++;
      end
   endtask

   task automatic check_last(input string name, input logic expv, input logic actv);
      if (actv !== expv) begin
         $display("FAILED t=%0t %s expected %b actual %b", $time, name, expv, actv);
         value_errs++;
      end
   endtask

   always @(posedge clk) begin
      if (!i_reset && o_tvalid && o_tready) begin
         n_recv++;
         if (exp_metric.size() == 0) begin
            $display("ERROR at %0t: a result came out with no input sample to match it", $time);
            count_errs++;
         end else begin
            check_metric("o_tdata", exp_metric.pop_front(), o_tdata);
            check_last("o_tlast", exp_last.pop_front(), o_tlast);
         end
         if (capture_sel == 1)
            first_run.push_back(o_tdata);
         else if (capture_sel == 2)
            second_run.push_back(o_tdata);
      end
   end

   // back-pressure from the sink
   initial begin
      o_tready  = 1'b1;
      rng_ready = xorshift32(SEED);
      forever begin
         @(negedge clk);
         if (stall_en) begin
            rng_ready = xorshift32(rng_ready);
            o_tready  = (rng_ready[1:0] != 2'b00);
         end else begin
            o_tready  = 1'b1;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic void add_noise(input int len, input int shift);
      int k;
      for (k = 0; k < len; k++)
         pkt.push_back(random_sample(shift));
   endfunction

   function automatic void add_preamble(input int reps, input int shift);
      iq_t pattern [DELAY_LEN];
      int  r;
      int  k;
      for (k = 0; k < DELAY_LEN; k++)
         pattern[k] = random_sample(shift);
      for (r = 0; r < reps; r++)
         for (k = 0; k < DELAY_LEN; k++)
            pkt.push_back(pattern[k]);
   endfunction

   function automatic void add_zeros(input int len);
      int k;
      for (k = 0; k < len; k++)
         pkt.push_back('0);
   endfunction

   task automatic send_sample(input iq_t x, input logic last);
      int waited;
      int gap;
      bit fired;
      if (stall_en) begin
         rng_data = xorshift32(rng_data);
         gap = (rng_data[1:0] == 2'b00) ? int'(rng_data[4:2]) : 0;
         repeat (gap) @(negedge clk);          // idle cycles on i_tvalid
      end
      hist.push_back(x);
      exp_metric.push_back(sc_metric(hist.size() - 1));
      exp_last.push_back(last);
      n_sent++;
      i_tdata  = x;
      i_tlast  = last;
      i_tvalid = 1'b1;
      fired  = 1'b0;
      waited = 0;
      while (!fired && !abort) begin
         @(posedge clk);
         fired = i_tready;
         @(negedge clk);
         waited++;
         if (!fired && waited >= SEND_TIMEOUT) begin
            $display("input sample %0d was not accepted within %0d cycles", n_sent - 1,
                     SEND_TIMEOUT);
            timeouts++;
            abort = 1'b1;
         end
      end
      i_tvalid = 1'b0;
   endtask

   task automatic send_packet();
      int k;
      for (k = 0; k < pkt.size(); k++) begin
         if (!abort) begin
            if (record) begin
               replay_d.push_back(pkt[k]);
               replay_l.push_back(k == pkt.size() - 1);
            end
            send_sample(pkt[k], k == pkt.size() - 1);
         end
      end
      pkt.delete();
   endtask

   task automatic replay_recorded();
      int k;
      for (k = 0; k < replay_d.size(); k++)
         if (!abort)
            send_sample(replay_d[k], replay_l[k]);
   endtask

   task automatic drain_outputs();
      int waited;
      waited = 0;
      while (exp_metric.size() != 0 && !abort) begin
         @(negedge clk);
         waited++;
         if (waited >= DRAIN_TIMEOUT) begin
            $display("%0d results were still missing after %0d cycles", exp_metric.size(),
                     DRAIN_TIMEOUT);
            timeouts++;
            abort = 1'b1;
         end
      end
      repeat (4) @(negedge clk);
   endtask

   task automatic pulse_clear();
      @(negedge clk);
      i_clear = 1'b1;
      @(negedge clk);
      i_clear = 1'b0;
      hist.delete();                            // reference restarts from zero too
   endtask

   initial begin
      int k;
      i_reset  = 1'b1;
      i_clear  = 1'b0;
      i_tdata  = '0;
      i_tlast  = 1'b0;
      i_tvalid = 1'b0;
      repeat (8) @(negedge clk);
      i_reset  = 1'b0;

      // unstalled noise packet, then a preamble in noise
      record      = 1'b1;
      capture_sel = 1;
      add_noise(400, 0);
      send_packet();
      add_noise(100, 2);
      add_preamble(20, 1);
      add_noise(80, 2);
      send_packet();
      drain_outputs();
      record      = 1'b0;
      capture_sel = 0;

      // zero input gives zero power
      pulse_clear();
      add_zeros(200);
      send_packet();
      drain_outputs();

      // same samples again under stalls
      pulse_clear();
      stall_en    = 1'b1;
      capture_sel = 2;
      replay_recorded();
      drain_outputs();
      stall_en    = 1'b0;
      capture_sel = 0;

      if (n_recv != n_sent) begin
         $display("got %0d results for %0d input samples", n_recv, n_sent);
         count_errs++;
      end
      if (first_run.size() != second_run.size()) begin
         $display("stalled run gave %0d results, unstalled run gave %0d", second_run.size(),
                  first_run.size());
         count_errs++;
      end else begin
         for (k = 0; k < first_run.size(); k++)
            check_metric("o_tdata (stalled replay)", first_run[k], second_run[k]);
      end
      $display("errors: %0d value, %0d count, %0d timeout; samples in %0d, results out %0d",
               value_errs, count_errs, timeouts, n_sent, n_recv);
      if (value_errs == 0 && count_errs == 0 && timeouts == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: vlog.f
hw/sc_sample_pkg.sv
hw/sc_detect_pkg.sv
hw/axis_if.sv
hw/stream_fork.sv
hw/sample_delay.sv
hw/conj_mult.sv
hw/moving_sum.sv
hw/complex_to_magsq.sv
hw/metric_divide.sv
hw/schmidl_cox.sv
verif/schmidl_cox_tb.sv
